//--- logic/imu_data_pkg.sv
`default_nettype none

package imu_data_pkg;

    // ==============================
    // Sensor words
    // ==============================
    typedef logic signed [15:0] sample_t;   // One raw sensor word, no Q scaling

    typedef struct packed {
        sample_t w;
        sample_t x;
        sample_t y;
        sample_t z;
    } quat_t;                               // Rotation vector, 64 bits

    typedef struct packed {
        sample_t x;
        sample_t y;
        sample_t z;
    } gyro_t;                               // Angular rate, 48 bits

    // Quaternion sits in the upper bits so it goes out first
    typedef struct packed {
        quat_t quat;
        gyro_t gyro;
    } imu_sample_t;                         // 112 bits per sensor

    // Report ids that carry data
    localparam logic [7:0] REPORT_ID_QUAT = 8'h05;
    localparam logic [7:0] REPORT_ID_GYRO = 8'h02;

    localparam int MCU_PACKET_BYTES = 28;   // Two imu_sample_t back to back

endpackage

`default_nettype wire

//--- logic/sensor_bus_pkg.sv
`default_nettype none

package sensor_bus_pkg;

    // ==============================
    // Shared sensor SPI bus
    // ==============================
    typedef logic [7:0] spi_byte_t;

    localparam int NUM_SENSORS  = 2;        // Left and right hand
    localparam int REPORT_BYTES = 9;        // Id byte plus four LE words

    typedef logic [0:0] sensor_id_t;

    // Reader to bus
    typedef struct packed {
        logic      req;                     // Held for the whole report
        logic      tx_valid;                // Byte strobe
        spi_byte_t tx_data;
    } bus_req_t;

    // Bus to reader, zero for the reader without the grant
    typedef struct packed {
        logic      gnt;                     // Level while owner
        logic      tx_ready;
        logic      rx_valid;                // One cycle per byte
        spi_byte_t rx_data;
        logic      busy;
    } bus_rsp_t;

endpackage

`default_nettype wire

//--- logic/board_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module board_sequencer #(
    parameter int SENSOR_RST_CYCLES = 300_000,   // 100 ms at 3 MHz
    parameter int LOGIC_RST_CYCLES  = 6_000_000, // 2 s at 3 MHz
    parameter int HEARTBEAT_BIT     = 21
) (
    input  logic clk,
    input  logic fpga_rst_n,
    output logic bno085_rst_n,
    output logic logic_rst_n,
    output logic led_heartbeat
);

    logic [$clog2(LOGIC_RST_CYCLES + 1)-1:0] rst_cnt;  // Saturates at the logic delay
    logic [HEARTBEAT_BIT:0]                  hb_cnt;

    // Sensor reset is released first, the rest of the FPGA later
    always_ff @(posedge clk or negedge fpga_rst_n) begin
        if (!fpga_rst_n) begin
            rst_cnt      <= '0;
            bno085_rst_n <= 1'b0;
            logic_rst_n  <= 1'b0;
        end else begin
            if (rst_cnt < LOGIC_RST_CYCLES)
                rst_cnt <= rst_cnt + 1'b1;
            bno085_rst_n <= (rst_cnt >= SENSOR_RST_CYCLES - 1);  // High on cycle N
            logic_rst_n  <= (rst_cnt >= LOGIC_RST_CYCLES - 1);   // Sticky since count saturates
        end
    end

    // Heartbeat only runs once the logic is out of reset
    always_ff @(posedge clk or negedge logic_rst_n) begin
        if (!logic_rst_n)
            hb_cnt <= '0;
        else
            hb_cnt <= hb_cnt + 1'b1;
    end

    assign led_heartbeat = hb_cnt[HEARTBEAT_BIT];

endmodule

`default_nettype wire

//--- logic/sensor_spi_master.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_spi_master import sensor_bus_pkg::*; #(
    parameter int CLK_DIV = 2                   // clk cycles per sclk half period
) (
    input  logic     clk,
    input  logic     rst_n,
    input  bus_req_t req,
    output bus_rsp_t rsp,
    output logic     sclk,
    output logic     mosi,
    input  logic     miso
);

    typedef enum logic {ST_IDLE, ST_SHIFT} state_t;

    state_t                       state;
    logic [$clog2(CLK_DIV+1)-1:0] div_cnt;      // Position inside one half period
    logic [3:0]                   phase;        // 16 half periods, even ones have sclk low
    spi_byte_t                    shreg;        // Out on mosi, fills from miso
    logic                         miso_bit;     // Held from rising to falling edge
    logic                         rx_pulse;
    logic                         accept;
    logic                         half_end;

    assign accept   = (state == ST_IDLE) && req.req && req.tx_valid;
    assign half_end = (state == ST_SHIFT) && (div_cnt == CLK_DIV - 1);

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            div_cnt  <= '0;
            phase    <= '0;
            sclk     <= 1'b0;                   // Mode 0 idles low
            rx_pulse <= 1'b0;
        end else begin
            rx_pulse <= 1'b0;
            if (accept) begin
                state   <= ST_SHIFT;
                div_cnt <= '0;
                phase   <= '0;
            end else if (half_end) begin
                div_cnt <= '0;
                phase   <= phase + 4'd1;
                sclk    <= ~phase[0];           // Rise after even, fall after odd
                if (phase == 4'd15) begin
                    state    <= ST_IDLE;        // tx_ready back with rx_valid
                    rx_pulse <= 1'b1;
                end
            end else if (state == ST_SHIFT) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Data path, sample on rise and shift on fall
    always_ff @(posedge clk) begin
        if (accept)
            shreg <= req.tx_data;
        else if (half_end && !phase[0])
            miso_bit <= miso;
        else if (half_end)
            shreg <= {shreg[6:0], miso_bit};
    end

    assign mosi = (state == ST_SHIFT) && shreg[7];  // Low between bytes
    assign rsp  = '{gnt:      1'b0,             // Grant comes from the arbiter
                    tx_ready: state == ST_IDLE,
                    rx_valid: rx_pulse,
                    rx_data:  shreg,
                    busy:     state == ST_SHIFT};

endmodule

`default_nettype wire

//--- logic/sensor_bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_bus_arbiter import sensor_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  bus_req_t               rdr_req [NUM_SENSORS],
    output bus_rsp_t               rdr_rsp [NUM_SENSORS],
    output bus_req_t               mst_req,
    input  bus_rsp_t               mst_rsp,
    input  logic [NUM_SENSORS-1:0] miso,
    output logic                   mst_miso
);

    sensor_id_t owner;
    sensor_id_t prio;           // First in line for the next grant
    sensor_id_t pick;
    logic       owned;
    logic       pick_valid;

    // Round robin search starting at prio
    always_comb begin
        pick_valid = 1'b0;
        pick       = prio;
        for (int i = NUM_SENSORS - 1; i >= 0; i--) begin
            if (rdr_req[sensor_id_t'(prio + i)].req) begin
                pick_valid = 1'b1;
                pick       = sensor_id_t'(prio + i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owned <= 1'b0;
            owner <= '0;
            prio  <= '0;
        end else if (!owned && pick_valid) begin
            owned <= 1'b1;                              // Held for a whole report
            owner <= pick;
        end else if (owned && !rdr_req[owner].req) begin
            owned <= 1'b0;
            prio  <= sensor_id_t'(owner + 1);           // Other reader first next time
        end
    end

    // Steering, non-owners see an all-zero response
    always_comb begin
        mst_req = '{req:      owned,
                    tx_valid: owned && rdr_req[owner].tx_valid,
                    tx_data:  rdr_req[owner].tx_data};
        for (int i = 0; i < NUM_SENSORS; i++) begin
            rdr_rsp[i] = '0;
            if (owned && owner == sensor_id_t'(i)) begin
                rdr_rsp[i]     = mst_rsp;
                rdr_rsp[i].gnt = 1'b1;
            end
        end
    end

    assign mst_miso = owned && miso[owner];

endmodule

`default_nettype wire

//--- logic/imu_report_reader.sv
`timescale 1ns/10ps
`default_nettype none

module imu_report_reader import imu_data_pkg::*, sensor_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     int_n,         // Low while a report is waiting
    output bus_req_t bus_req,
    input  bus_rsp_t bus_rsp,
    output logic     cs_n,
    output quat_t    quat,
    output logic     quat_valid,
    output gyro_t    gyro,
    output logic     gyro_valid,
    output logic     initialized,
    output logic     error
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_REQUEST, ST_SELECT, ST_SEND, ST_WAIT_BYTE, ST_RELEASE, ST_DECODE
    } state_t;

    state_t                            state;
    logic [$clog2(REPORT_BYTES)-1:0]   byte_cnt;
    logic [REPORT_BYTES*8-1:0]         rpt;         // First byte ends up in [7:0]
    spi_byte_t                         rpt_id;

    assign rpt_id = rpt[7:0];

    // ==============================
    // Report FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            byte_cnt    <= '0;
            cs_n        <= 1'b1;
            initialized <= 1'b0;
            error       <= 1'b0;
        end else begin
            case (state)
                ST_IDLE:    if (!int_n) state <= ST_REQUEST;
                ST_REQUEST: if (bus_rsp.gnt) begin
                    state <= ST_SELECT;
                    cs_n  <= 1'b0;              // Cycle after the grant
                end
                ST_SELECT: begin
                    state    <= ST_SEND;
                    byte_cnt <= '0;
                end
                ST_SEND:    if (bus_rsp.tx_ready) state <= ST_WAIT_BYTE;
                ST_WAIT_BYTE: if (bus_rsp.rx_valid) begin
                    if (byte_cnt == REPORT_BYTES - 1) begin
                        state <= ST_RELEASE;
                        cs_n  <= 1'b1;          // Last byte in, deselect
                    end else begin
                        state    <= ST_SEND;
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                ST_RELEASE: begin
                    state <= ST_DECODE;
                    if (rpt_id == REPORT_ID_QUAT || rpt_id == REPORT_ID_GYRO)
                        initialized <= 1'b1;
                    else
                        error <= 1'b1;          // Sticky, data left alone
                end
                default:    state <= ST_IDLE;   // ST_DECODE
            endcase
        end
    end

    // Bytes shift in from the top, so the LE words line up naturally
    always_ff @(posedge clk) begin
        if (state == ST_WAIT_BYTE && bus_rsp.rx_valid)
            rpt <= {bus_rsp.rx_data, rpt[REPORT_BYTES*8-1:8]};
        if (state == ST_RELEASE && rpt_id == REPORT_ID_QUAT)
            quat <= '{w: sample_t'(rpt[23:8]),  x: sample_t'(rpt[39:24]),
                      y: sample_t'(rpt[55:40]), z: sample_t'(rpt[71:56])};
        if (state == ST_RELEASE && rpt_id == REPORT_ID_GYRO)
            gyro <= '{x: sample_t'(rpt[23:8]),  y: sample_t'(rpt[39:24]),
                      z: sample_t'(rpt[55:40])};    // Fourth word ignored
    end

    assign bus_req = '{req:      state inside {ST_REQUEST, ST_SELECT, ST_SEND, ST_WAIT_BYTE},
                       tx_valid: (state == ST_SEND) && bus_rsp.tx_ready,
                       tx_data:  8'h00};            // Dummy byte, reads only

    // Valid in the cycle the new data is visible
    assign quat_valid = (state == ST_DECODE) && (rpt_id == REPORT_ID_QUAT);
    assign gyro_valid = (state == ST_DECODE) && (rpt_id == REPORT_ID_GYRO);

endmodule

`default_nettype wire

//--- logic/mcu_spi_slave.sv
`timescale 1ns/10ps
`default_nettype none

module mcu_spi_slave import imu_data_pkg::*, sensor_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mcu_cs_n,
    input  logic                   mcu_sck,        // At most clk/8, MCU samples on rise
    input  logic                   mcu_sdi,        // Write direction not supported
    output logic                   mcu_sdo,
    input  quat_t                  sensor_quat [NUM_SENSORS],
    input  logic [NUM_SENSORS-1:0] quat_valid,
    input  gyro_t                  sensor_gyro [NUM_SENSORS],
    input  logic [NUM_SENSORS-1:0] gyro_valid
);

    imu_sample_t                   hold [NUM_SENSORS];  // Latest value per sensor
    logic [1:0]                    cs_sync;
    logic [1:0]                    sck_sync;
    logic                          cs_q;                // Previous synchronized level
    logic                          sck_q;
    logic                          cs_fall;
    logic                          sck_fall;
    logic [MCU_PACKET_BYTES*8-1:0] shreg;

    // ==============================
    // Holding registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SENSORS; i++)
                hold[i] <= '0;
        end else begin
            for (int i = 0; i < NUM_SENSORS; i++) begin
                if (quat_valid[i]) hold[i].quat <= sensor_quat[i];
                if (gyro_valid[i]) hold[i].gyro <= sensor_gyro[i];
            end
        end
    end

    // Two-flop synchronizers plus edge history
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_sync  <= 2'b11;
            sck_sync <= 2'b00;
            cs_q     <= 1'b1;
            sck_q    <= 1'b0;
        end else begin
            cs_sync  <= {cs_sync[0], mcu_cs_n};
            sck_sync <= {sck_sync[0], mcu_sck};
            cs_q     <= cs_sync[1];
            sck_q    <= sck_sync[1];
        end
    end

    assign cs_fall  = cs_q && !cs_sync[1];
    assign sck_fall = sck_q && !sck_sync[1];

    // Snapshot at select, then one bit per falling sck
    always_ff @(posedge clk) begin
        if (cs_fall)
            shreg <= {hold[0], hold[1]};                 // Sensor 0 first, MSB first
        else if (sck_fall && !cs_q)
            shreg <= {shreg[MCU_PACKET_BYTES*8-2:0], mcu_sdi};
    end

    assign mcu_sdo = !cs_q && shreg[MCU_PACKET_BYTES*8-1];  // Quiet while deselected

endmodule

`default_nettype wire

//--- logic/drum_trigger_top.sv
`timescale 1ns/10ps
`default_nettype none

module drum_trigger_top import imu_data_pkg::*, sensor_bus_pkg::*; #(
    parameter int SENSOR_RST_CYCLES = 300_000,
    parameter int LOGIC_RST_CYCLES  = 6_000_000,
    parameter int HEARTBEAT_BIT     = 21,
    parameter int CLK_DIV           = 2
) (
    input  logic                   clk,
    input  logic                   fpga_rst_n,
    // MCU link, FPGA is the slave
    input  logic                   mcu_sck,
    input  logic                   mcu_sdi,
    input  logic                   mcu_cs_n,
    output logic                   mcu_sdo,
    // Shared sensor bus
    output logic                   sclk,
    output logic                   mosi,
    input  logic [NUM_SENSORS-1:0] miso,
    output logic                   cs_n0,
    output logic                   cs_n1,
    input  logic [NUM_SENSORS-1:0] int_n,
    output logic                   bno085_rst_n,
    // Status LEDs
    output logic                   led_initialized,
    output logic                   led_error,
    output logic                   led_heartbeat
);

    logic                   logic_rst_n;
    bus_req_t               rdr_req [NUM_SENSORS];
    bus_rsp_t               rdr_rsp [NUM_SENSORS];
    bus_req_t               mst_req;
    bus_rsp_t               mst_rsp;
    logic                   mst_miso;
    logic [NUM_SENSORS-1:0] rdr_cs_n;
    quat_t                  rdr_quat [NUM_SENSORS];
    gyro_t                  rdr_gyro [NUM_SENSORS];
    logic [NUM_SENSORS-1:0] quat_valid;
    logic [NUM_SENSORS-1:0] gyro_valid;
    logic [NUM_SENSORS-1:0] rdr_init;
    logic [NUM_SENSORS-1:0] rdr_err;

    board_sequencer #(
        .SENSOR_RST_CYCLES (SENSOR_RST_CYCLES),
        .LOGIC_RST_CYCLES  (LOGIC_RST_CYCLES),
        .HEARTBEAT_BIT     (HEARTBEAT_BIT)
    ) u_seq (
        .clk, .fpga_rst_n, .bno085_rst_n, .logic_rst_n, .led_heartbeat
    );

    sensor_spi_master #(.CLK_DIV(CLK_DIV)) u_master (
        .clk, .rst_n(logic_rst_n), .req(mst_req), .rsp(mst_rsp), .sclk, .mosi, .miso(mst_miso)
    );

    sensor_bus_arbiter u_arb (
        .clk, .rst_n(logic_rst_n), .rdr_req, .rdr_rsp, .mst_req, .mst_rsp, .miso, .mst_miso
    );

    // One reader per hand
    for (genvar i = 0; i < NUM_SENSORS; i++) begin : g_reader
        imu_report_reader u_reader (
            .clk, .rst_n(logic_rst_n), .int_n(int_n[i]),
            .bus_req(rdr_req[i]), .bus_rsp(rdr_rsp[i]), .cs_n(rdr_cs_n[i]),
            .quat(rdr_quat[i]), .quat_valid(quat_valid[i]),
            .gyro(rdr_gyro[i]), .gyro_valid(gyro_valid[i]),
            .initialized(rdr_init[i]), .error(rdr_err[i])
        );
    end

    mcu_spi_slave u_mcu (
        .clk, .rst_n(logic_rst_n), .mcu_cs_n, .mcu_sck, .mcu_sdi, .mcu_sdo,
        .sensor_quat(rdr_quat), .quat_valid, .sensor_gyro(rdr_gyro), .gyro_valid
    );

    assign {cs_n1, cs_n0}   = rdr_cs_n;
    assign led_initialized = &rdr_init;    // Both hands have reported
    assign led_error       = |rdr_err;

endmodule

`default_nettype wire

//--- dv/imu_sensor_model.sv
`timescale 1ns/10ps
`default_nettype none

module imu_sensor_model (
    input  logic sclk,
    input  logic cs_n,
    output logic miso,
    output logic int_n              // Low while a report is queued
);

    logic [71:0] rpt_mem [16];      // Small report queue, wraps
    logic [71:0] shreg;             // Id byte leaves first, MSB first
    int          pushed = 0;
    int          popped = 0;

    assign int_n = (pushed == popped);
    assign miso  = !cs_n && shreg[71];

    // Words go out little-endian after the id byte
    task automatic push_report(input logic [7:0] id, input logic [3:0][15:0] words);
        rpt_mem[pushed % 16] = {id,
                                words[0][7:0], words[0][15:8], words[1][7:0], words[1][15:8],
                                words[2][7:0], words[2][15:8], words[3][7:0], words[3][15:8]};
        pushed++;
    endtask

    always @(negedge cs_n)
        shreg = rpt_mem[popped % 16];   // First bit valid before the first rise

    always @(negedge sclk)
        if (!cs_n) shreg = {shreg[70:0], 1'b0};    // Mode 0, change on fall

    // Deselect ends the report
    always @(posedge cs_n)
        if (pushed != popped) popped++;

endmodule

`default_nettype wire

//--- dv/drum_trigger_checker.sv
`timescale 1ns/10ps
`default_nettype none

module drum_trigger_checker import imu_data_pkg::*; #(
    parameter int SENSOR_RST_CYCLES = 20
) (
    input  logic clk,
    input  logic fpga_rst_n,
    input  logic logic_rst_n,
    input  logic bno085_rst_n,
    input  logic cs_n0,
    input  logic cs_n1,
    input  logic mosi,
    input  logic led_heartbeat,
    input  logic led_initialized,
    input  logic led_error,
    input  logic mcu_sdo,
    output logic mcu_cs_n,          // Checker plays the MCU
    output logic mcu_sck,
    output logic mcu_sdi
);

    int   errors     = 0;
    int   reads      = 0;
    int   rst_cycles = 0;           // Rising edges since board reset release
    int   hb_toggles = 0;
    logic hb_last    = 1'b0;
    logic rst_bad    = 1'b0;
    logic mosi_bad   = 1'b0;

    initial begin
        mcu_cs_n = 1'b1;
        mcu_sck  = 1'b0;
        mcu_sdi  = 1'b0;            // Write direction unused
    end

    // ==============================
    // Reset and LED monitors
    // ==============================
    always @(posedge clk or negedge fpga_rst_n)
        if (!fpga_rst_n) rst_cycles <= 0;
        else             rst_cycles <= rst_cycles + 1;

    always @(negedge clk) begin
        if (bno085_rst_n !== (rst_cycles >= SENSOR_RST_CYCLES)) begin
            errors++;
            if (!rst_bad)
                $display("ERR reset_seq bno085_rst_n expected %b actual %b",
                         rst_cycles >= SENSOR_RST_CYCLES, bno085_rst_n);
            rst_bad = 1'b1;
        end
        if (logic_rst_n !== 1'b1 && (cs_n0 !== 1'b1 || cs_n1 !== 1'b1)) begin
            errors++;
            $display("A sensor chip select went low while the logic was still in reset");
        end
        // Readers only ever send the 0x00 dummy byte
        if (logic_rst_n === 1'b1 && mosi !== 1'b0) begin
            errors++;
            if (!mosi_bad)
                $display("ERR mosi_dummy mosi expected 0 actual %b", mosi);
            mosi_bad = 1'b1;
        end
        if (led_heartbeat !== hb_last) begin
            hb_toggles++;
            hb_last = led_heartbeat;
        end
    end

    task automatic check_heartbeat();
        if (hb_toggles < 2) begin
            errors++;
            $display("The heartbeat LED did not toggle during the run");
        end
    endtask

    // ==============================
    // MCU packet read with sck at clk/10
    // ==============================
    task automatic read_packet(input logic [95:0] name, input logic [223:0] exp_pkt,
                               input logic exp_init, input logic exp_err);
        logic [223:0] got;
        logic [15:0]  exp_word;
        logic [15:0]  got_word;
        @(negedge clk);
        mcu_cs_n = 1'b0;
        repeat (10) @(negedge clk);         // Synchronizer plus snapshot
        for (int b = MCU_PACKET_BYTES*8 - 1; b >= 0; b--) begin
            mcu_sck = 1'b1;
            got[b]  = mcu_sdo;              // MCU samples on the rising edge
            repeat (5) @(negedge clk);
            mcu_sck = 1'b0;
            repeat (5) @(negedge clk);
        end
        mcu_cs_n = 1'b1;
        repeat (4) @(negedge clk);
        for (int w = 0; w < MCU_PACKET_BYTES / 2; w++) begin
            exp_word = exp_pkt[223 - 16*w -: 16];
            got_word = got[223 - 16*w -: 16];
            if (got_word !== exp_word) begin
                errors++;
                $display("ERR %0s word %0d expected %h actual %h",
                         name, w, exp_word, got_word);
            end
        end
        if (led_initialized !== exp_init) begin
            errors++;
            $display("ERR %0s led_initialized expected %b actual %b",
                     name, exp_init, led_initialized);
        end
        if (led_error !== exp_err) begin
            errors++;
            $display("ERR %0s led_error expected %b actual %b", name, exp_err, led_error);
        end
        reads++;
    endtask

endmodule

`default_nettype wire

//--- dv/drum_trigger_props.sv
`timescale 1ns/10ps
`default_nettype none

module drum_trigger_props (
    input logic clk,
    input logic fpga_rst_n,
    input logic bno085_rst_n,
    input logic cs_n0,
    input logic cs_n1,
    input logic sclk
);

    int unsigned fail_count = 0;    // Read by the testbench at the end

    // Sensor held in reset must never be selected
    a_quiet_in_sensor_rst: assert property (@(posedge clk) disable iff (!fpga_rst_n)
        !bno085_rst_n |-> cs_n0 && cs_n1)
        else begin
            $error("Sensor chip select low while the sensor reset is asserted");
            fail_count++;
        end

    a_one_owner: assert property (@(posedge clk) disable iff (!fpga_rst_n)
        !(!cs_n0 && !cs_n1))
        else begin
            $error("Both sensor chip selects low together");
            fail_count++;
        end

    a_sclk_idle: assert property (@(posedge clk) disable iff (!fpga_rst_n)
        cs_n0 && cs_n1 |-> !sclk)       // Mode 0 idle level
        else begin
            $error("Sensor sclk high with no sensor selected");
            fail_count++;
        end

endmodule

bind drum_trigger_top drum_trigger_props u_props (
    .clk(clk), .fpga_rst_n(fpga_rst_n), .bno085_rst_n(bno085_rst_n),
    .cs_n0(cs_n0), .cs_n1(cs_n1), .sclk(sclk)
);

`default_nettype wire

//--- dv/drum_trigger_tb.sv
`timescale 1ns/10ps
`default_nettype none

module drum_trigger_tb import imu_data_pkg::*, sensor_bus_pkg::*;;

    localparam int SENSOR_RST = 20;
    localparam int LOGIC_RST  = 60;
    localparam int HB_BIT     = 4;
    localparam int DIV        = 2;
    localparam int NUM_ROWS   = 10;
    localparam int TIMEOUT    = NUM_ROWS * (2*9*16*DIV + 28*8*10 + 50)
                                + SENSOR_RST + LOGIC_RST + 4;

    typedef enum logic {ACT_QUEUE, ACT_READ} action_t;

    typedef struct packed {
        logic [95:0]      name;
        action_t          action;
        logic [1:0]       mask;         // Bit per sensor
        logic [7:0]       id;
        logic [3:0][15:0] words;        // words[0] is sent first
    } row_t;

    logic                   clk        = 1'b0;
    logic                   fpga_rst_n = 1'b0;
    logic                   mcu_sck, mcu_sdi, mcu_cs_n, mcu_sdo;
    logic                   sclk, mosi, cs_n0, cs_n1, bno085_rst_n;
    logic                   led_initialized, led_error, led_heartbeat;
    wire  [1:0]             miso;
    wire  [1:0]             int_n;
    row_t                   rows [NUM_ROWS];
    int                     n_rows    = 0;
    int                     cycle_cnt = 0;
    imu_sample_t            exp_hold [NUM_SENSORS];    // Reference snapshot
    logic [NUM_SENSORS-1:0] exp_init  = '0;
    logic [NUM_SENSORS-1:0] exp_err   = '0;

    always #20 clk = ~clk;              // 40 ns period

    drum_trigger_top #(
        .SENSOR_RST_CYCLES (SENSOR_RST),
        .LOGIC_RST_CYCLES  (LOGIC_RST),
        .HEARTBEAT_BIT     (HB_BIT),
        .CLK_DIV           (DIV)
    ) DUT (
        .clk, .fpga_rst_n, .mcu_sck, .mcu_sdi, .mcu_cs_n, .mcu_sdo,
        .sclk, .mosi, .miso, .cs_n0, .cs_n1, .int_n, .bno085_rst_n,
        .led_initialized, .led_error, .led_heartbeat
    );

    imu_sensor_model u_sensor0 (.sclk, .cs_n(cs_n0), .miso(miso[0]), .int_n(int_n[0]));
    imu_sensor_model u_sensor1 (.sclk, .cs_n(cs_n1), .miso(miso[1]), .int_n(int_n[1]));

    drum_trigger_checker #(.SENSOR_RST_CYCLES(SENSOR_RST)) u_checker (
        .clk, .fpga_rst_n, .logic_rst_n(DUT.logic_rst_n), .bno085_rst_n, .cs_n0, .cs_n1,
        .mosi, .led_heartbeat, .led_initialized, .led_error, .mcu_sdo, .mcu_cs_n,
        .mcu_sck, .mcu_sdi
    );

    // ==============================
    // Table and reference model
    // ==============================
    task automatic add_row(input logic [95:0] name, input action_t action,
                           input logic [1:0] mask, input logic [7:0] id);
        rows[n_rows] = '{name: name, action: action, mask: mask, id: id, words: '0};
        if (action == ACT_QUEUE)
            rows[n_rows].words = {$urandom(), $urandom()};    // Random data words
        n_rows++;
    endtask

    // Quat takes all four words and gyro the first three
    task automatic update_reference(input row_t r);
        for (int s = 0; s < NUM_SENSORS; s++) begin
            if (r.mask[s] && r.id == REPORT_ID_QUAT) begin
                exp_hold[s].quat = '{w: r.words[0], x: r.words[1],
                                     y: r.words[2], z: r.words[3]};
                exp_init[s] = 1'b1;
            end else if (r.mask[s] && r.id == REPORT_ID_GYRO) begin
                exp_hold[s].gyro = '{x: r.words[0], y: r.words[1], z: r.words[2]};
                exp_init[s] = 1'b1;
            end else if (r.mask[s]) begin
                exp_err[s] = 1'b1;          // Data unchanged
            end
        end
    endtask

    // Sensor 0 then sensor 1, quat w..z then gyro x..z
    function automatic logic [223:0] expected_packet();
        return {exp_hold[0].quat.w, exp_hold[0].quat.x, exp_hold[0].quat.y, exp_hold[0].quat.z,
                exp_hold[0].gyro.x, exp_hold[0].gyro.y, exp_hold[0].gyro.z,
                exp_hold[1].quat.w, exp_hold[1].quat.x, exp_hold[1].quat.y, exp_hold[1].quat.z,
                exp_hold[1].gyro.x, exp_hold[1].gyro.y, exp_hold[1].gyro.z};
    endfunction

    task automatic apply_row(input row_t r);
        if (r.action == ACT_QUEUE) begin
            if (r.mask[0]) u_sensor0.push_report(r.id, r.words);
            if (r.mask[1]) u_sensor1.push_report(r.id, r.words);   // Same cycle
            update_reference(r);
            @(negedge clk);
            while (int_n !== 2'b11) @(negedge clk);                // Reports consumed
            repeat (4) @(negedge clk);                             // Decode and hold
        end else begin
            u_checker.read_packet(r.name, expected_packet(), &exp_init, |exp_err);
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int seed_ret;
        int total;
        seed_ret = $urandom(51);
        for (int s = 0; s < NUM_SENSORS; s++)
            exp_hold[s] = '0;
        add_row("quat_s0",    ACT_QUEUE, 2'b01, REPORT_ID_QUAT);
        add_row("quat_s0_rd", ACT_READ,  2'b00, 8'h00);
        add_row("quat_s1",    ACT_QUEUE, 2'b10, REPORT_ID_QUAT);
        add_row("init_rd",    ACT_READ,  2'b00, 8'h00);
        add_row("gyro_both",  ACT_QUEUE, 2'b11, REPORT_ID_GYRO);
        add_row("gyro_rd",    ACT_READ,  2'b00, 8'h00);
        add_row("quat_both",  ACT_QUEUE, 2'b11, REPORT_ID_QUAT);
        add_row("both_rd",    ACT_READ,  2'b00, 8'h00);
        add_row("bad_id",     ACT_QUEUE, 2'b01, 8'h3c);
        add_row("bad_id_rd",  ACT_READ,  2'b00, 8'h00);
        repeat (4) @(negedge clk);
        fpga_rst_n = 1'b1;
        // First report waits on int_n while the sequencer still holds the logic in reset
        for (int i = 0; i < n_rows; i++)
            apply_row(rows[i]);
        u_checker.check_heartbeat();
        total = u_checker.errors + DUT.u_props.fail_count;
        $display("Rows %0d, packet reads %0d, check errors %0d, assertion failures %0d",
                 n_rows, u_checker.reads, u_checker.errors, DUT.u_props.fail_count);
        if (total == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // Cycle limit from the row count and reset delays
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT) begin
            $display("Timeout after %0d cycles, the rows did not complete", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- drum_trigger.f
logic/imu_data_pkg.sv
logic/sensor_bus_pkg.sv
logic/board_sequencer.sv
logic/sensor_spi_master.sv
logic/sensor_bus_arbiter.sv
logic/imu_report_reader.sv
logic/mcu_spi_slave.sv
logic/drum_trigger_top.sv
dv/imu_sensor_model.sv
dv/drum_trigger_checker.sv
dv/drum_trigger_props.sv
dv/drum_trigger_tb.sv

//--- Bender.yml
package:
  name: drum_trigger

sources:
  - logic/imu_data_pkg.sv
  - logic/sensor_bus_pkg.sv
  - logic/board_sequencer.sv
  - logic/sensor_spi_master.sv
  - logic/sensor_bus_arbiter.sv
  - logic/imu_report_reader.sv
  - logic/mcu_spi_slave.sv
  - logic/drum_trigger_top.sv
  - target: simulation
    files:
      - dv/imu_sensor_model.sv
      - dv/drum_trigger_checker.sv
      - dv/drum_trigger_props.sv
      - dv/drum_trigger_tb.sv
